// File: hdl/bp2wb_convertor.sv
`timescale 1ns/1ps

module bp2wb_convertor
   import bp_sys_pkg::*;
(
   input  logic               clk_i,
   input  logic               rst_i,
   input  logic               cfg_done_i,
   // Head of the command FIFO
   input  logic               cmd_ready_i,
   input  mem_op_e            cmd_op_i,
   input  mem_size_e          cmd_size_i,
   input  logic [PADDR_W-1:0] cmd_addr_i,
   input  logic [DWORD_W-1:0] cmd_data_i,
   output logic               cmd_pop_o,
   // Wishbone master
   input  logic [DWORD_W-1:0] wbm_dat_i,
   input  logic               wbm_ack_i,
   input  logic               wbm_err_i,
   output logic [DWORD_W-1:0] wbm_dat_o,
   output logic [PADDR_W-1:0] wbm_adr_o,
   output logic [SEL_W-1:0]   wbm_sel_o,
   output logic               wbm_we_o,
   output logic               wbm_stb_o,
   output logic               wbm_cyc_o,
   output logic [2:0]         wbm_cti_o,
   output logic [1:0]         wbm_bte_o,
   // Memory response
   output logic               mem_resp_v_o,
   output mem_op_e            mem_resp_op_o,
   output logic [DWORD_W-1:0] mem_resp_data_o,
   output logic               mem_resp_err_o
);

   // Low address bits that pick the first byte lane
   localparam int LANE_W = $clog2(SEL_W);
   // Classic cycle, linear burst
   localparam logic [2:0] CTI_CLASSIC = 3'b000;
   localparam logic [1:0] BTE_LINEAR  = 2'b00;

   wb_state_e          state_r;
   wb_state_e          state_n;
   logic               pop;
   logic               bus_done;

   // Command held for the whole bus cycle
   mem_op_e            op_r;
   logic [PADDR_W-1:0] addr_r;
   logic [DWORD_W-1:0] data_r;
   logic [SEL_W-1:0]   sel_r;

   logic [SEL_W-1:0]   sel_base;
   logic [SEL_W-1:0]   sel_n;

   logic [DWORD_W-1:0] resp_data_r;
   logic               resp_err_r;

   // Memory side stays frozen until config is written
   assign pop      = (state_r == e_wb_idle) & cfg_done_i & cmd_ready_i;
   // First cycle with ack or err ends the transfer
   assign bus_done = (state_r == e_wb_bus) & (wbm_ack_i | wbm_err_i);

   // Lane mask from the size, lane 0 based
   always_comb
   begin
      case (cmd_size_i)
         e_size_1: sel_base = SEL_W'(1);
         e_size_2: sel_base = SEL_W'(3);
         e_size_4: sel_base = SEL_W'(15);
         default:  sel_base = '1;
      endcase
   end

   // Aligned access, so the shift never spills
   assign sel_n = sel_base << cmd_addr_i[LANE_W-1:0];

   always_comb
   begin
      state_n = state_r;
      case (state_r)
         e_wb_idle:
         begin
            if (pop)
               state_n = e_wb_bus;
         end
         e_wb_bus:
         begin
            if (bus_done)
               state_n = e_wb_resp;
         end
         // Single response cycle, back to idle
         e_wb_resp: state_n = e_wb_idle;
         default:   state_n = e_wb_idle;
      endcase
   end

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
         state_r <= e_wb_idle;
      else
         state_r <= state_n;
   end

   // Latch the head entry on pop
   always_ff @(posedge clk_i)
   begin
      if (pop)
      begin
         op_r   <= cmd_op_i;
         addr_r <= cmd_addr_i;
         data_r <= cmd_data_i;
         sel_r  <= sel_n;
      end
   end

   // Build the response when the slave answers
   always_ff @(posedge clk_i)
   begin
      if (bus_done)
      begin
         resp_err_r <= wbm_err_i;
         // Read data only on a clean read ack
         if (wbm_ack_i & ~wbm_err_i & (op_r == e_mem_rd))
            resp_data_r <= wbm_dat_i;
         else
            resp_data_r <= '0;
      end
   end

   assign cmd_pop_o = pop;

   // Strobe and cycle together for the whole bus state
   assign wbm_stb_o = (state_r == e_wb_bus);
   assign wbm_cyc_o = (state_r == e_wb_bus);
   assign wbm_we_o  = (op_r == e_mem_wr);
   assign wbm_adr_o = addr_r;
   assign wbm_dat_o = data_r;
   assign wbm_sel_o = sel_r;
   assign wbm_cti_o = CTI_CLASSIC;
   assign wbm_bte_o = BTE_LINEAR;

   // One-cycle response pulse, cycle after ack or err
   assign mem_resp_v_o    = (state_r == e_wb_resp);
   assign mem_resp_op_o   = op_r;
   assign mem_resp_data_o = resp_data_r;
   assign mem_resp_err_o  = resp_err_r;

endmodule

// File: hdl/bp_cfg_loader.sv
`timescale 1ns/1ps

module bp_cfg_loader
   import bp_sys_pkg::*;
#(
   parameter int IO_CREDITS = 2
)
(
   input  logic                  clk_i,
   input  logic                  rst_i,
   input  logic                  io_cmd_credit_i,
   output logic                  io_cmd_v_o,
   output logic [CFG_ADDR_W-1:0] io_cmd_addr_o,
   output logic [DWORD_W-1:0]    io_cmd_data_o,
   output logic                  cfg_done_o
);

   localparam int IDX_W = (CFG_WORDS > 1) ? $clog2(CFG_WORDS) : 1;
   localparam int CRD_W = $clog2(IO_CREDITS + 1);

   cfg_state_e            state_r;
   cfg_state_e            state_n;
   logic [IDX_W-1:0]      idx_r;
   logic [CRD_W-1:0]      credits_r;
   logic [CRD_W-1:0]      credits_n;
   logic                  issue;
   logic                  last_word;

   // Registered I/O command
   logic                  v_r;
   logic [CFG_ADDR_W-1:0] addr_r;
   logic [DWORD_W-1:0]    data_r;

   // One word per cycle while a credit is held
   assign issue     = (state_r == e_cfg_send) & (credits_r != '0);
   assign last_word = (idx_r == IDX_W'(CFG_WORDS - 1));
   // Spend on issue, refill on each returned pulse
   assign credits_n = credits_r - CRD_W'(issue) + CRD_W'(io_cmd_credit_i);

   always_comb
   begin
      state_n = state_r;
      case (state_r)
         e_cfg_send:
         begin
            if (issue & last_word)
               state_n = e_cfg_drain;
         end
         // Done once every credit is back
         e_cfg_drain:
         begin
            if (credits_n == CRD_W'(IO_CREDITS))
               state_n = e_cfg_done;
         end
         e_cfg_done: state_n = e_cfg_done;
         default:    state_n = e_cfg_send;
      endcase
   end

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         state_r   <= e_cfg_send;
         idx_r     <= '0;
         credits_r <= CRD_W'(IO_CREDITS);
         v_r       <= 1'b0;
      end
      else
      begin
         state_r   <= state_n;
         credits_r <= credits_n;
         v_r       <= issue;
         if (issue)
            idx_r <= idx_r + 1'b1;
      end
   end

   // Table entry goes out the cycle after issue
   always_ff @(posedge clk_i)
   begin
      if (issue)
      begin
         addr_r <= cfg_addr_table[idx_r];
         data_r <= cfg_data_table[idx_r];
      end
   end

   assign io_cmd_v_o    = v_r;
   assign io_cmd_addr_o = addr_r;
   assign io_cmd_data_o = data_r;
   // Sticky until the next reset
   assign cfg_done_o    = (state_r == e_cfg_done);

endmodule

// File: hdl/bp_cmd_fifo.sv
`timescale 1ns/1ps

module bp_cmd_fifo
   import bp_sys_pkg::*;
#(
   parameter int CMD_DEPTH = 4
)
(
   input  logic               clk_i,
   input  logic               rst_i,
   input  logic               push_i,
   input  mem_op_e            push_op_i,
   input  mem_size_e          push_size_i,
   input  logic [PADDR_W-1:0] push_addr_i,
   input  logic [DWORD_W-1:0] push_data_i,
   input  logic               pop_i,
   output mem_op_e            head_op_o,
   output mem_size_e          head_size_o,
   output logic [PADDR_W-1:0] head_addr_o,
   output logic [DWORD_W-1:0] head_data_o,
   output logic               not_empty_o,
   output logic               credit_o
);

   localparam int PTR_W = (CMD_DEPTH > 1) ? $clog2(CMD_DEPTH) : 1;
   localparam int CNT_W = $clog2(CMD_DEPTH + 1);

   // Command storage, one slot per credit
   mem_op_e            op_mem   [CMD_DEPTH];
   mem_size_e          size_mem [CMD_DEPTH];
   logic [PADDR_W-1:0] addr_mem [CMD_DEPTH];
   logic [DWORD_W-1:0] data_mem [CMD_DEPTH];

   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             full;
   logic             wr_en;
   logic             rd_en;

   // Pointer step with wrap for any depth
   function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
      return (ptr == PTR_W'(CMD_DEPTH - 1)) ? '0 : ptr + 1'b1;
   endfunction

   assign full        = (count == CNT_W'(CMD_DEPTH));
   assign not_empty_o = (count != '0);
   // Sender holds a credit, so a full push is dropped
   assign wr_en       = push_i & ~full;
   assign rd_en       = pop_i & not_empty_o;

   always_ff @(posedge clk_i)
   begin
      if (wr_en)
      begin
         op_mem[wr_ptr]   <= push_op_i;
         size_mem[wr_ptr] <= push_size_i;
         addr_mem[wr_ptr] <= push_addr_i;
         data_mem[wr_ptr] <= push_data_i;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (wr_en)
            wr_ptr <= ptr_inc(wr_ptr);
         if (rd_en)
            rd_ptr <= ptr_inc(rd_ptr);
         count <= count + CNT_W'(wr_en) - CNT_W'(rd_en);
      end
   end

   // Head entry, read straight from storage
   assign head_op_o   = op_mem[rd_ptr];
   assign head_size_o = size_mem[rd_ptr];
   assign head_addr_o = addr_mem[rd_ptr];
   assign head_data_o = data_mem[rd_ptr];

   // Slot freed this cycle, hand the credit back
   assign credit_o = rd_en;

endmodule

// File: hdl/bp_sys_pkg.sv
package bp_sys_pkg;

   // Physical address, matches the Wishbone address bus
   localparam int PADDR_W = 37;
   // Data word
   localparam int DWORD_W = 64;
   // One select bit per byte lane
   localparam int SEL_W = DWORD_W / 8;

   // I/O config space address
   localparam int CFG_ADDR_W = 20;
   // Length of the boot-time config sequence
   localparam int CFG_WORDS = 4;

   // Config write addresses, sent in index order
   // Freeze release goes out last
   localparam logic [CFG_ADDR_W-1:0] cfg_addr_table [CFG_WORDS] = '{
      20'h0_0004,
      20'h0_0008,
      20'h0_0010,
      20'h0_0000
   };

   // Config write data, one entry per address above
   localparam logic [DWORD_W-1:0] cfg_data_table [CFG_WORDS] = '{
      64'h0000_0000_0000_0000,
      64'h0000_0000_0000_0001,
      64'h0000_0000_0000_0002,
      64'h0000_0000_0000_0000
   };

   // Memory command opcodes
   typedef enum logic {e_mem_rd = 1'b0, e_mem_wr = 1'b1} mem_op_e;

   // Access size in bytes, 1 to 8
   typedef enum logic [1:0] {
      e_size_1 = 2'b00,
      e_size_2 = 2'b01,
      e_size_4 = 2'b10,
      e_size_8 = 2'b11
   } mem_size_e;

   // Bridge FSM
   typedef enum logic [1:0] {e_wb_idle, e_wb_bus, e_wb_resp} wb_state_e;

   // Config loader FSM
   typedef enum logic [1:0] {e_cfg_send, e_cfg_drain, e_cfg_done} cfg_state_e;

endpackage

// File: hdl/bp_wb_system.sv
`timescale 1ns/1ps

module bp_wb_system
   import bp_sys_pkg::*;
#(
   parameter int CMD_DEPTH  = 4,
   parameter int IO_CREDITS = 2
)
(
   input  logic                  clk_i,
   input  logic                  rst_i,
   // Memory command from the core
   input  logic                  mem_cmd_v_i,
   input  mem_op_e               mem_cmd_op_i,
   input  mem_size_e             mem_cmd_size_i,
   input  logic [PADDR_W-1:0]    mem_cmd_addr_i,
   input  logic [DWORD_W-1:0]    mem_cmd_data_i,
   output logic                  mem_cmd_credit_o,
   // Memory response to the core
   output logic                  mem_resp_v_o,
   output mem_op_e               mem_resp_op_o,
   output logic [DWORD_W-1:0]    mem_resp_data_o,
   output logic                  mem_resp_err_o,
   // I/O config command
   output logic                  io_cmd_v_o,
   output logic [CFG_ADDR_W-1:0] io_cmd_addr_o,
   output logic [DWORD_W-1:0]    io_cmd_data_o,
   input  logic                  io_cmd_credit_i,
   output logic                  cfg_done_o,
   // Wishbone master
   input  logic [DWORD_W-1:0]    wbm_dat_i,
   input  logic                  wbm_ack_i,
   input  logic                  wbm_err_i,
   output logic [DWORD_W-1:0]    wbm_dat_o,
   output logic [PADDR_W-1:0]    wbm_adr_o,
   output logic [SEL_W-1:0]      wbm_sel_o,
   output logic                  wbm_we_o,
   output logic                  wbm_stb_o,
   output logic                  wbm_cyc_o,
   output logic [2:0]            wbm_cti_o,
   output logic [1:0]            wbm_bte_o
);

   // FIFO head to bridge
   mem_op_e            head_op;
   mem_size_e          head_size;
   logic [PADDR_W-1:0] head_addr;
   logic [DWORD_W-1:0] head_data;
   logic               head_v;
   logic               head_pop;

   // Loader releases the memory path
   logic               cfg_done;

   assign cfg_done_o = cfg_done;

   // Buffer sized to the sender's credit pool
   bp_cmd_fifo #(
      .CMD_DEPTH(CMD_DEPTH)
   ) cmd_fifo_i (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .push_i     (mem_cmd_v_i),
      .push_op_i  (mem_cmd_op_i),
      .push_size_i(mem_cmd_size_i),
      .push_addr_i(mem_cmd_addr_i),
      .push_data_i(mem_cmd_data_i),
      .pop_i      (head_pop),
      .head_op_o  (head_op),
      .head_size_o(head_size),
      .head_addr_o(head_addr),
      .head_data_o(head_data),
      .not_empty_o(head_v),
      .credit_o   (mem_cmd_credit_o)
   );

   bp2wb_convertor bp2wb_i (
      .clk_i          (clk_i),
      .rst_i          (rst_i),
      .cfg_done_i     (cfg_done),
      .cmd_ready_i    (head_v),
      .cmd_op_i       (head_op),
      .cmd_size_i     (head_size),
      .cmd_addr_i     (head_addr),
      .cmd_data_i     (head_data),
      .cmd_pop_o      (head_pop),
      .wbm_dat_i      (wbm_dat_i),
      .wbm_ack_i      (wbm_ack_i),
      .wbm_err_i      (wbm_err_i),
      .wbm_dat_o      (wbm_dat_o),
      .wbm_adr_o      (wbm_adr_o),
      .wbm_sel_o      (wbm_sel_o),
      .wbm_we_o       (wbm_we_o),
      .wbm_stb_o      (wbm_stb_o),
      .wbm_cyc_o      (wbm_cyc_o),
      .wbm_cti_o      (wbm_cti_o),
      .wbm_bte_o      (wbm_bte_o),
      .mem_resp_v_o   (mem_resp_v_o),
      .mem_resp_op_o  (mem_resp_op_o),
      .mem_resp_data_o(mem_resp_data_o),
      .mem_resp_err_o (mem_resp_err_o)
   );

   // Post-reset config writer
   bp_cfg_loader #(
      .IO_CREDITS(IO_CREDITS)
   ) cfg_loader_i (
      .clk_i          (clk_i),
      .rst_i          (rst_i),
      .io_cmd_credit_i(io_cmd_credit_i),
      .io_cmd_v_o     (io_cmd_v_o),
      .io_cmd_addr_o  (io_cmd_addr_o),
      .io_cmd_data_o  (io_cmd_data_o),
      .cfg_done_o     (cfg_done)
   );

endmodule

// File: list.f
hdl/bp_sys_pkg.sv
hdl/bp_cmd_fifo.sv
hdl/bp2wb_convertor.sv
hdl/bp_cfg_loader.sv
hdl/bp_wb_system.sv
verification/tb_bp_wb_system.sv

// File: verification/bp_wb_vectors.txt
# C cfg_addr cfg_data : expected I/O config write, in order
# T op size addr wdata rdata err sel : op 1 write, size 0..3 for 1..8 bytes
C 00004 0000000000000000
C 00008 0000000000000001
C 00010 0000000000000002
C 00000 0000000000000000
# Sent before the loader is done
T 1 3 0000001000 1122334455667788 0000000000000000 0 ff
T 0 3 0000001000 0000000000000000 a5a5a5a5deadbeef 0 ff
T 1 0 0000001003 00000000ab000000 0000000000000000 0 08
# Single commands
T 0 2 0000001004 0000000000000000 0123456789abcdef 0 f0
T 1 1 0000002006 5a5a000000000000 0000000000000000 0 c0
# Read with a bus error
T 0 1 0000002002 0000000000000000 00000000cafe0000 1 0c
# Burst against the slow slave
T 1 2 0000003000 00000000feedface 0000000000000000 0 0f
T 0 0 0000003001 0000000000000000 0000000000007700 0 02
T 1 3 0000003008 0f0e0d0c0b0a0908 0000000000000000 0 ff
# Write with a bus error
T 1 0 0000003007 1200000000000000 0000000000000000 1 80
T 0 2 000000300c 0000000000000000 89abcdef00000000 0 f0
T 0 3 1fffffff00 0000000000000000 fedcba9876543210 0 ff

// File: verification/tb_bp_wb_system.sv
`timescale 1ns/1ps

module tb_bp_wb_system
   import bp_sys_pkg::*;
();

   localparam int CMD_DEPTH  = 4;
   localparam int IO_CREDITS = 2;
   localparam int MAX_TR     = 32;
   localparam int TIMEOUT    = 200;
   // Commands sent while the loader is still busy
   localparam int N_EARLY    = 3;
   localparam int BURST      = CMD_DEPTH + 2;

   logic               clk_i = 1'b0;
   logic               rst_i;
   logic               mem_cmd_v_i;
   mem_op_e            mem_cmd_op_i;
   mem_size_e          mem_cmd_size_i;
   logic [PADDR_W-1:0] mem_cmd_addr_i;
   logic [DWORD_W-1:0] mem_cmd_data_i;
   logic               io_cmd_credit_i;
   logic [DWORD_W-1:0] wbm_dat_i;
   logic               wbm_ack_i;
   logic               wbm_err_i;

   logic                  mem_cmd_credit_o;
   logic                  mem_resp_v_o;
   mem_op_e               mem_resp_op_o;
   logic [DWORD_W-1:0]    mem_resp_data_o;
   logic                  mem_resp_err_o;
   logic                  io_cmd_v_o;
   logic [CFG_ADDR_W-1:0] io_cmd_addr_o;
   logic [DWORD_W-1:0]    io_cmd_data_o;
   logic                  cfg_done_o;
   logic [DWORD_W-1:0]    wbm_dat_o;
   logic [PADDR_W-1:0]    wbm_adr_o;
   logic [SEL_W-1:0]      wbm_sel_o;
   logic                  wbm_we_o;
   logic                  wbm_stb_o;
   logic                  wbm_cyc_o;
   logic [2:0]            wbm_cti_o;
   logic [1:0]            wbm_bte_o;

   // Expected config writes
   logic [CFG_ADDR_W-1:0] cfg_addr_exp [CFG_WORDS];
   logic [DWORD_W-1:0]    cfg_data_exp [CFG_WORDS];
   int                    num_cfg;
   // Transaction vectors
   logic                  tr_op    [MAX_TR];
   logic [1:0]            tr_size  [MAX_TR];
   logic [PADDR_W-1:0]    tr_addr  [MAX_TR];
   logic [DWORD_W-1:0]    tr_wdata [MAX_TR];
   logic [DWORD_W-1:0]    tr_rdata [MAX_TR];
   logic                  tr_err   [MAX_TR];
   logic [SEL_W-1:0]      tr_sel   [MAX_TR];
   int                    num_tr;

   integer seed = 32'h8ea3fdc4;
   int     cycle = 0;
   int     i;
   // Memory credit bookkeeping
   int     credits = CMD_DEPTH;
   int     credits_back = 0;
   int     sent_cnt = 0;
   logic   credit_prev = 1'b0;
   // Vector indices waiting on the bus and for a response
   int     bus_q [$];
   int     resp_q [$];
   // I/O credit return schedule
   int     io_due_q [$];
   int     io_last_due = 0;
   int     io_last_back = 0;
   int     io_back = 0;
   int     cfg_seen = 0;
   logic   done_seen = 1'b0;
   int     due;
   // Slave model state
   logic   slave_busy = 1'b0;
   int     slave_wait = 0;
   int     extra_wait = 0;
   int     slave_idx;

   bp_wb_system #(
      .CMD_DEPTH (CMD_DEPTH),
      .IO_CREDITS(IO_CREDITS)
   ) bp_wb_system_i (.*);

   always #4 clk_i = ~clk_i;

   task automatic check_value(input string name, input logic [63:0] actual,
                              input logic [63:0] expected);
      if (actual !== expected)
      begin
         $display("Error at %0t: %s is %h, expected %h", $time, name, actual, expected);
         $display("sim failed");
         $fatal(1, "mismatch on %s", name);
      end
   endtask

   task automatic timeout_fail(input string what);
      $display("Timed out at %0t while waiting for %s", $time, what);
      $display("sim failed");
      $fatal(1, "timeout");
   endtask

   task automatic load_vectors();
      int               fd;
      int               code;
      logic [7:0]       kind;
      logic [8*200-1:0] rest;
      logic [63:0]      f0, f1, f2, f3, f4, f5, f6;
      num_cfg = 0;
      num_tr  = 0;
      fd = $fopen("verification/bp_wb_vectors.txt", "r");
      if (fd == 0)
      begin
         $display("Could not open the vector file");
         $display("sim failed");
         $fatal(1, "no vectors");
      end
      else
      begin
         while (!$feof(fd))
         begin
            code = $fscanf(fd, " %c", kind);
            if (code == 1 && kind == "#")
               code = $fgets(rest, fd);
            else if (code == 1 && kind == "C")
            begin
               code = $fscanf(fd, "%h %h", f0, f1);
               cfg_addr_exp[num_cfg] = f0[CFG_ADDR_W-1:0];
               cfg_data_exp[num_cfg] = f1;
               num_cfg++;
            end
            else if (code == 1 && kind == "T")
            begin
               code = $fscanf(fd, "%h %h %h %h %h %h %h", f0, f1, f2, f3, f4, f5, f6);
               tr_op[num_tr]    = f0[0];
               tr_size[num_tr]  = f1[1:0];
               tr_addr[num_tr]  = f2[PADDR_W-1:0];
               tr_wdata[num_tr] = f3;
               tr_rdata[num_tr] = f4;
               tr_err[num_tr]   = f5[0];
               tr_sel[num_tr]   = f6[SEL_W-1:0];
               num_tr++;
            end
         end
         $fclose(fd);
         check_value("config lines in vector file", num_cfg, CFG_WORDS);
         check_value("enough transaction lines", num_tr >= N_EARLY + BURST, 1);
      end
   endtask

   // Write and error responses carry no data
   function automatic logic [63:0] expect_resp_data(input int idx);
      if (tr_err[idx] || tr_op[idx])
         return '0;
      return tr_rdata[idx];
   endfunction

   // Caller sits 1 ns after a rising edge
   task automatic send_cmd(input int idx);
      int waited;
      waited = 0;
      while (credits == 0)
      begin
         @(posedge clk_i);
         #1;
         waited++;
         if (waited > TIMEOUT)
            timeout_fail("a memory command credit");
      end
      credits--;
      sent_cnt++;
      bus_q.push_back(idx);
      resp_q.push_back(idx);
      mem_cmd_v_i    = 1'b1;
      mem_cmd_op_i   = mem_op_e'(tr_op[idx]);
      mem_cmd_size_i = mem_size_e'(tr_size[idx]);
      mem_cmd_addr_i = tr_addr[idx];
      mem_cmd_data_i = tr_wdata[idx];
      @(posedge clk_i);
      #1;
      mem_cmd_v_i = 1'b0;
   endtask

   task automatic wait_responses(input string what);
      int waited;
      waited = 0;
      while (resp_q.size() != 0)
      begin
         @(posedge clk_i);
         #1;
         waited++;
         if (waited > TIMEOUT)
            timeout_fail(what);
      end
   endtask

   task automatic wait_cfg_done();
      int waited;
      waited = 0;
      while (cfg_done_o !== 1'b1)
      begin
         @(posedge clk_i);
         #1;
         waited++;
         if (waited > TIMEOUT)
            timeout_fail("cfg_done_o");
      end
   endtask

   // Bus fields must hold for the whole transfer
   task automatic check_bus_request(input int idx);
      check_value("wbm_stb_o", wbm_stb_o, 1);
      check_value("wbm_adr_o", wbm_adr_o, tr_addr[idx]);
      check_value("wbm_we_o", wbm_we_o, tr_op[idx]);
      check_value("wbm_sel_o", wbm_sel_o, tr_sel[idx]);
      if (tr_op[idx])
         check_value("wbm_dat_o", wbm_dat_o, tr_wdata[idx]);
   endtask

   // Wishbone slave with 0 to 3 random wait states plus an extra stall
   always
   begin
      @(posedge clk_i);
      #1;
      wbm_ack_i = 1'b0;
      wbm_err_i = 1'b0;
      wbm_dat_i = '0;
      if (wbm_cyc_o === 1'b1)
      begin
         check_value("bus cycle with a command sent", bus_q.size() != 0, 1);
         slave_idx = bus_q[0];
         check_bus_request(slave_idx);
         if (!slave_busy)
         begin
            slave_busy = 1'b1;
            slave_wait = $unsigned($random(seed)) % 4 + extra_wait;
         end
         if (slave_wait == 0)
         begin
            wbm_ack_i  = ~tr_err[slave_idx];
            wbm_err_i  = tr_err[slave_idx];
            wbm_dat_i  = tr_rdata[slave_idx];
            slave_busy = 1'b0;
            void'(bus_q.pop_front());
         end
         else
            slave_wait--;
      end
   end

   // Cycle count and I/O credit return
   always
   begin
      @(posedge clk_i);
      #1;
      cycle++;
      io_cmd_credit_i = 1'b0;
      if (io_due_q.size() != 0 && io_due_q[0] == cycle)
      begin
         io_cmd_credit_i = 1'b1;
         void'(io_due_q.pop_front());
      end
   end

   // Monitors sample mid-cycle
   always @(negedge clk_i)
   begin
      if (rst_i === 1'b1)
      begin
         check_value("io_cmd_v_o in reset", io_cmd_v_o, 0);
         check_value("wbm_cyc_o in reset", wbm_cyc_o, 0);
         check_value("wbm_stb_o in reset", wbm_stb_o, 0);
         check_value("mem_resp_v_o in reset", mem_resp_v_o, 0);
         check_value("mem_cmd_credit_o in reset", mem_cmd_credit_o, 0);
         check_value("cfg_done_o in reset", cfg_done_o, 0);
      end
      else
      begin
         check_value("wbm_cti_o", wbm_cti_o, 0);
         check_value("wbm_bte_o", wbm_bte_o, 0);
         // Memory side frozen until config is written
         if (wbm_cyc_o === 1'b1)
            check_value("cfg_done_o while wbm_cyc_o high", cfg_done_o, 1);
         // A credit marks a pop, so the bus cycle starts next
         if (credit_prev)
            check_value("wbm_cyc_o after a credit", wbm_cyc_o, 1);
         credit_prev = (mem_cmd_credit_o === 1'b1);
         if (mem_cmd_credit_o === 1'b1)
         begin
            check_value("mem_cmd_credit_o for a sent command", credits_back < sent_cnt, 1);
            credits++;
            credits_back++;
         end
         if (io_cmd_credit_i === 1'b1)
         begin
            io_back++;
            io_last_back = cycle;
         end
         if (io_cmd_v_o === 1'b1)
         begin
            check_value("io_cmd_v_o within CFG_WORDS", cfg_seen < CFG_WORDS, 1);
            check_value("io_cmd_addr_o", io_cmd_addr_o, cfg_addr_exp[cfg_seen]);
            check_value("io_cmd_data_o", io_cmd_data_o, cfg_data_exp[cfg_seen]);
            cfg_seen++;
            // Returns kept in order 1 to 3 cycles out
            due = cycle + 1 + $unsigned($random(seed)) % 3;
            if (due <= io_last_due)
               due = io_last_due + 1;
            io_last_due = due;
            io_due_q.push_back(due);
         end
         if (cfg_done_o === 1'b1 && !done_seen)
         begin
            done_seen = 1'b1;
            check_value("I/O commands at cfg_done_o", cfg_seen, CFG_WORDS);
            check_value("I/O credits back at cfg_done_o", io_back, CFG_WORDS);
            check_value("cycles from last I/O credit", cycle - io_last_back, 1);
         end
         if (mem_resp_v_o === 1'b1)
         begin
            check_value("response with a command outstanding", resp_q.size() != 0, 1);
            check_value("mem_resp_op_o", mem_resp_op_o, tr_op[resp_q[0]]);
            check_value("mem_resp_err_o", mem_resp_err_o, tr_err[resp_q[0]]);
            check_value("mem_resp_data_o", mem_resp_data_o, expect_resp_data(resp_q[0]));
            void'(resp_q.pop_front());
         end
      end
   end

   initial
   begin
      rst_i           = 1'b1;
      mem_cmd_v_i     = 1'b0;
      mem_cmd_op_i    = e_mem_rd;
      mem_cmd_size_i  = e_size_1;
      mem_cmd_addr_i  = '0;
      mem_cmd_data_i  = '0;
      io_cmd_credit_i = 1'b0;
      wbm_dat_i       = '0;
      wbm_ack_i       = 1'b0;
      wbm_err_i       = 1'b0;
      load_vectors();
      repeat (3) @(posedge clk_i);
      #1;
      rst_i = 1'b0;
      // These wait in the FIFO until the loader finishes
      for (i = 0; i < N_EARLY; i++)
         send_cmd(i);
      check_value("cfg_done_o after early commands", cfg_done_o, 0);
      wait_cfg_done();
      wait_responses("the early responses");
      // Single commands one at a time
      for (i = N_EARLY; i < num_tr - BURST; i++)
      begin
         send_cmd(i);
         wait_responses("a single response");
      end
      // Slow slave fills the FIFO and holds back credits
      extra_wait = 4;
      for (i = num_tr - BURST; i < num_tr; i++)
         send_cmd(i);
      wait_responses("the burst responses");
      check_value("credits returned", credits_back, sent_cnt);
      check_value("I/O commands", cfg_seen, CFG_WORDS);
      $display("sim passed");
      $finish;
   end

   // Hard stop for a stuck run
   initial
   begin
      #100000;
      timeout_fail("the end of the run");
   end

endmodule
